// File: hw/fp_add_pkg.sv
package fp_add_pkg;

    // IEEE-754 single precision field widths
    localparam int EXP_W   = 8;
    localparam int FRAC_W  = 23;
    localparam int MANT_W  = 24;
    // mantissa plus guard, round and sticky
    localparam int ALIGN_W = 27;
    localparam int SUM_W   = 29;

    localparam logic [EXP_W-1:0] EXP_MAX   = 8'd255;
    localparam logic [31:0]      QNAN_WORD = 32'hFFFF_FFFF;
    localparam logic [2:0]       SEQ_LAST  = 3'd7;

    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exponent;
        logic [FRAC_W-1:0] frac;
    } fp_word_t;

    // mantissa carries the hidden bit, zero for flushed inputs
    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exponent;
        logic [MANT_W-1:0] mant;
        logic              is_nan;
        logic              is_inf;
    } fp_operand_t;

    typedef struct packed {
        fp_operand_t a;
        fp_operand_t b;
        logic        op;
    } fp_capture_t;

    typedef struct packed {
        logic [ALIGN_W-1:0] mant_a;
        logic [ALIGN_W-1:0] mant_b;
        logic [EXP_W-1:0]   exponent;
    } fp_aligned_t;

    typedef struct packed {
        logic               sign;
        logic [SUM_W-2:0]   mag;
        logic [EXP_W-1:0]   exponent;
    } fp_magnitude_t;

    // exponent kept signed so underflow and overflow stay visible
    typedef struct packed {
        logic               sign;
        logic signed [9:0]  exponent;
        logic [FRAC_W-1:0]  frac;
    } fp_rounded_t;

endpackage

// File: hw/fp_add_seq.sv
`timescale 1ns/1ps

module fp_add_seq (
    input  logic sys_clk,
    input  logic sys_rst_n,
    input  logic trig,
    output logic capture_en,
    output logic finish
);

    logic [2:0] step;
    logic       idle;

    assign idle       = (step == 3'd0);
    // trig only counts while nothing is in flight
    assign capture_en = idle & trig;
    assign finish     = (step == fp_add_pkg::SEQ_LAST);

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            step <= 3'd0;
        end else if (capture_en) begin
            step <= 3'd1;
        end else if (finish) begin
            step <= 3'd0;
        end else if (!idle) begin
            step <= step + 3'd1;
        end
    end

endmodule

// File: hw/fp_unpack.sv
`timescale 1ns/1ps

module fp_unpack (
    input  logic                   sys_clk,
    input  logic                   sys_rst_n,
    input  logic                   capture_en,
    input  fp_add_pkg::fp_word_t   data1_in,
    input  fp_add_pkg::fp_word_t   data2_in,
    input  logic                   op,
    output fp_add_pkg::fp_capture_t capture
);

    // split one word and classify it
    function automatic fp_add_pkg::fp_operand_t unpack_word(
        input fp_add_pkg::fp_word_t w
    );
        fp_add_pkg::fp_operand_t o;
        logic                    exp_ones;
        logic                    frac_zero;
        exp_ones   = (w.exponent == fp_add_pkg::EXP_MAX);
        frac_zero  = (w.frac == '0);
        o.sign     = w.sign;
        o.exponent = w.exponent;
        // denormals flush to zero, no hidden bit
        o.mant     = (w.exponent == '0) ? '0 : {1'b1, w.frac};
        o.is_nan   = exp_ones & ~frac_zero;
        o.is_inf   = exp_ones & frac_zero;
        return o;
    endfunction

    fp_add_pkg::fp_capture_t capture_d;

    assign capture_d.a  = unpack_word(data1_in);
    assign capture_d.b  = unpack_word(data2_in);
    assign capture_d.op = op;

    // held for the whole operation, pack reads it at the last step
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            capture <= '0;
        end else if (capture_en) begin
            capture <= capture_d;
        end
    end

endmodule

// File: hw/fp_align.sv
`timescale 1ns/1ps

module fp_align (
    input  logic                    sys_clk,
    input  logic                    sys_rst_n,
    input  fp_add_pkg::fp_capture_t capture,
    output fp_add_pkg::fp_aligned_t aligned
);

    localparam int EW      = fp_add_pkg::EXP_W;
    localparam int MW      = fp_add_pkg::MANT_W;
    localparam int FIELD_W = fp_add_pkg::ALIGN_W - 1;

    logic [EW:0]            exp_diff;
    logic [EW:0]            abs_diff;
    logic [EW-1:0]          shift_amt;
    logic [EW-1:0]          exp_big;
    // set when operand b has the smaller (or equal) exponent
    logic                   b_small;
    logic [MW-1:0]          small_mant;
    logic [MW-1:0]          big_mant;
    logic [2*FIELD_W-1:0]   wide;
    logic [FIELD_W-1:0]     shifted;
    logic                   sticky;

    ////////////////////
    // exponent difference

    assign exp_diff = {1'b0, capture.a.exponent} - {1'b0, capture.b.exponent};
    assign abs_diff = exp_diff[EW] ? (~exp_diff + 1'b1) : exp_diff;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            shift_amt <= '0;
            exp_big   <= '0;
            b_small   <= 1'b0;
        end else begin
            shift_amt <= abs_diff[EW-1:0];
            exp_big   <= exp_diff[EW] ? capture.b.exponent : capture.a.exponent;
            b_small   <= ~exp_diff[EW];
        end
    end

    ////////////////////
    // shift smaller mantissa, collect sticky

    always_comb begin
        small_mant = b_small ? capture.b.mant : capture.a.mant;
        big_mant   = b_small ? capture.a.mant : capture.b.mant;
        wide       = {small_mant, 2'b00, {FIELD_W{1'b0}}} >> shift_amt;
        if (shift_amt >= 8'(FIELD_W)) begin
            shifted = '0;
            sticky  = |small_mant;
        end else begin
            shifted = wide[2*FIELD_W-1:FIELD_W];
            sticky  = |wide[FIELD_W-1:0];
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            aligned <= '0;
        end else begin
            aligned.mant_a   <= b_small ? {big_mant, 3'b000} : {shifted, sticky};
            aligned.mant_b   <= b_small ? {shifted, sticky} : {big_mant, 3'b000};
            aligned.exponent <= exp_big;
        end
    end

endmodule

// File: hw/fp_signed_sum.sv
`timescale 1ns/1ps

module fp_signed_sum (
    input  logic                      sys_clk,
    input  logic                      sys_rst_n,
    input  fp_add_pkg::fp_capture_t   capture,
    input  fp_add_pkg::fp_aligned_t   aligned,
    output fp_add_pkg::fp_magnitude_t magnitude
);

    localparam int SW = fp_add_pkg::SUM_W;
    localparam int EW = fp_add_pkg::EXP_W;

    logic [SW-2:0] term_a;
    logic [SW-2:0] term_b;
    logic [SW-1:0] sum;
    logic [SW-1:0] sum_neg;
    logic [EW-1:0] exp_d1;
    logic [EW-1:0] exp_d2;

    assign sum_neg = ~sum + 1'b1;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            term_a    <= '0;
            term_b    <= '0;
            sum       <= '0;
            exp_d1    <= '0;
            exp_d2    <= '0;
            magnitude <= '0;
        end else begin
            // two's complement by sign, b also flipped by subtract
            term_a <= capture.a.sign ? (~{1'b0, aligned.mant_a} + 1'b1)
                                     : {1'b0, aligned.mant_a};
            term_b <= (capture.b.sign ^ capture.op) ? (~{1'b0, aligned.mant_b} + 1'b1)
                                                    : {1'b0, aligned.mant_b};
            exp_d1 <= aligned.exponent;
            sum    <= {term_a[SW-2], term_a} + {term_b[SW-2], term_b};
            exp_d2 <= exp_d1;
            // abs value and sign of the sum
            magnitude.sign     <= sum[SW-1];
            magnitude.mag      <= sum[SW-1] ? sum_neg[SW-2:0] : sum[SW-2:0];
            magnitude.exponent <= exp_d2;
        end
    end

endmodule

// File: hw/fp_normalize.sv
`timescale 1ns/1ps

module fp_normalize (
    input  logic                      sys_clk,
    input  logic                      sys_rst_n,
    input  fp_add_pkg::fp_magnitude_t magnitude,
    output fp_add_pkg::fp_rounded_t   rounded
);

    localparam int FW  = fp_add_pkg::FRAC_W;
    // top bit of the magnitude, one above the hidden position
    localparam int TOP = fp_add_pkg::SUM_W - 2;

    logic [4:0]        lead_pos;
    logic              nonzero;
    logic [TOP:0]      shifted;
    logic [FW-1:0]     frac_raw;
    logic              guard;
    logic              rest;
    logic              round_up;
    logic [FW:0]       frac_inc;
    logic signed [9:0] exp_adj;

    ////////////////////
    // leading one, left justify

    always_comb begin
        lead_pos = '0;
        for (int i = 0; i <= TOP; i++) begin
            if (magnitude.mag[i]) begin
                lead_pos = 5'(i);
            end
        end
        nonzero = |magnitude.mag;
        shifted = magnitude.mag << (5'(TOP) - lead_pos);
    end

    ////////////////////
    // nearest even on the four bits below the fraction

    always_comb begin
        frac_raw = shifted[TOP-1:TOP-FW];
        guard    = shifted[TOP-FW-1];
        // sticky from align sits in the lowest bit already
        rest     = |shifted[TOP-FW-2:0];
        round_up = guard & (rest | frac_raw[0]);
        frac_inc = {1'b0, frac_raw} + {{FW{1'b0}}, round_up};
        // bit 27 gives +1, bit 0 gives -26, rounding carry one more
        exp_adj  = $signed({2'b00, magnitude.exponent}) - 10'sd26
                 + $signed({5'b00000, lead_pos})
                 + $signed({9'd0, frac_inc[FW]});
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            rounded <= '0;
        end else if (!nonzero) begin
            rounded <= '0;
        end else begin
            rounded.sign     <= magnitude.sign;
            rounded.exponent <= exp_adj;
            rounded.frac     <= frac_inc[FW-1:0];
        end
    end

endmodule

// File: hw/fp_pack.sv
`timescale 1ns/1ps

module fp_pack (
    input  logic                    sys_clk,
    input  logic                    sys_rst_n,
    input  logic                    finish,
    input  fp_add_pkg::fp_capture_t capture,
    input  fp_add_pkg::fp_rounded_t rounded,
    output fp_add_pkg::fp_word_t    data_out,
    output logic                    vld
);

    localparam logic [fp_add_pkg::FRAC_W-1:0] FRAC_ZERO = '0;

    fp_add_pkg::fp_word_t result;
    logic                 eff_sign_b;

    // effective sign of b after the opcode
    assign eff_sign_b = capture.b.sign ^ capture.op;

    always_comb begin
        if (capture.a.is_nan || capture.b.is_nan) begin
            result = fp_add_pkg::QNAN_WORD;
        end else if (capture.a.is_inf && capture.b.is_inf
                     && (capture.a.sign != eff_sign_b)) begin
            result = fp_add_pkg::QNAN_WORD;
        end else if (capture.a.is_inf) begin
            result = {capture.a.sign, fp_add_pkg::EXP_MAX, FRAC_ZERO};
        end else if (capture.b.is_inf) begin
            result = {eff_sign_b, fp_add_pkg::EXP_MAX, FRAC_ZERO};
        end else if (rounded.exponent <= 10'sd0) begin
            // underflow to signed zero
            result = {rounded.sign, 31'd0};
        end else if (rounded.exponent >= $signed({2'b00, fp_add_pkg::EXP_MAX})) begin
            result = {rounded.sign, fp_add_pkg::EXP_MAX, FRAC_ZERO};
        end else begin
            result = {rounded.sign, rounded.exponent[7:0], rounded.frac};
        end
    end

    // result held until the next finish
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            data_out <= '0;
            vld      <= 1'b0;
        end else begin
            vld <= finish;
            if (finish) begin
                data_out <= result;
            end
        end
    end

endmodule

// File: hw/fp_add_top.sv
`timescale 1ns/1ps

module fp_add_top (
    input  logic                 sys_clk,
    input  logic                 sys_rst_n,
    input  fp_add_pkg::fp_word_t data1_in,
    input  fp_add_pkg::fp_word_t data2_in,
    input  logic                 op,
    input  logic                 trig,
    output fp_add_pkg::fp_word_t data_out,
    output logic                 vld
);

    logic                      capture_en;
    logic                      finish;
    fp_add_pkg::fp_capture_t   capture;
    fp_add_pkg::fp_aligned_t   aligned;
    fp_add_pkg::fp_magnitude_t magnitude;
    fp_add_pkg::fp_rounded_t   rounded;

    fp_add_seq u_seq (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .trig       (trig),
        .capture_en (capture_en),
        .finish     (finish)
    );

    fp_unpack u_unpack (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .capture_en (capture_en),
        .data1_in   (data1_in),
        .data2_in   (data2_in),
        .op         (op),
        .capture    (capture)
    );

    ////////////////////
    // datapath, one stage per cycle

    fp_align u_align (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .capture   (capture),
        .aligned   (aligned)
    );

    fp_signed_sum u_signed_sum (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .capture   (capture),
        .aligned   (aligned),
        .magnitude (magnitude)
    );

    fp_normalize u_normalize (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .magnitude (magnitude),
        .rounded   (rounded)
    );

    fp_pack u_pack (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .finish    (finish),
        .capture   (capture),
        .rounded   (rounded),
        .data_out  (data_out),
        .vld       (vld)
    );

endmodule

// File: verification/fp_add_asserts.sv
`timescale 1ns/1ps

module fp_add_asserts (
    input logic                 sys_clk,
    input logic                 sys_rst_n,
    input logic                 capture_en,
    input fp_add_pkg::fp_word_t data_out,
    input logic                 vld
);

    int fail_count = 0;

    // quiet through reset and the first cycle after release
    assert property (@(posedge sys_clk) !sys_rst_n |-> !vld)
        else begin
            $error("vld high while reset is asserted");
            fail_count++;
        end

    assert property (@(posedge sys_clk) $rose(sys_rst_n) |-> !vld)
        else begin
            $error("vld high in the first cycle after reset");
            fail_count++;
        end

    // one-cycle pulse only
    assert property (@(posedge sys_clk) disable iff (!sys_rst_n) vld |=> !vld)
        else begin
            $error("vld high on two consecutive cycles");
            fail_count++;
        end

    // fixed latency from the accepted trigger
    assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
                     vld == $past(capture_en, 8))
        else begin
            $error("vld not exactly 8 cycles after an accepted trigger");
            fail_count++;
        end

    assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
                     (data_out != $past(data_out)) |-> vld)
        else begin
            $error("data_out changed without vld");
            fail_count++;
        end

endmodule

bind fp_add_top fp_add_asserts u_asserts (
    .sys_clk    (sys_clk),
    .sys_rst_n  (sys_rst_n),
    .capture_en (capture_en),
    .data_out   (data_out),
    .vld        (vld)
);

// File: verification/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic sys_clk,
    output logic sys_rst_n
);

    localparam int HALF_NS    = 20;
    localparam int RST_CYCLES = 16;

    initial begin
        sys_clk = 1'b0;
        forever #HALF_NS sys_clk = ~sys_clk;
    end

    // released on a rising edge after 16 cycles
    initial begin
        sys_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge sys_clk);
        sys_rst_n <= 1'b1;
    end

endmodule

// File: verification/tb_fp_add.sv
`timescale 1ns/1ps

module tb_fp_add;

    localparam int N_TIMING   = 8;
    localparam int N_EXACT    = 40;
    // rounding, cancellation, specials, overflow
    localparam int N_FIXED    = 11;
    localparam int N_OPS      = N_TIMING + N_EXACT + N_FIXED;
    localparam int OP_CYCLES  = 12;
    localparam int VLD_WAIT   = 12;
    localparam int RST_CYCLES = 16;
    localparam int CLK_NS     = 40;

    logic                 sys_clk;
    logic                 sys_rst_n;
    fp_add_pkg::fp_word_t data1_in;
    fp_add_pkg::fp_word_t data2_in;
    logic                 op;
    logic                 trig;
    fp_add_pkg::fp_word_t data_out;
    logic                 vld;

    int test_checks;
    int test_errors;
    int total_checks;
    int total_errors;
    int tests_run;

    tb_clk_gen u_clk_gen (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n)
    );

    fp_add_top UUT (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .data1_in  (data1_in),
        .data2_in  (data2_in),
        .op        (op),
        .trig      (trig),
        .data_out  (data_out),
        .vld       (vld)
    );

    ////////////////////
    // reference model

    // integers below 2^21 encode exactly, leading one becomes the hidden bit
    function automatic fp_add_pkg::fp_word_t int_to_float(input int v);
        fp_add_pkg::fp_word_t w;
        int unsigned          mag;
        int                   lead;
        w    = '0;
        mag  = (v < 0) ? -v : v;
        lead = 0;
        for (int i = 0; i < 31; i++) begin
            if (mag[i]) begin
                lead = i;
            end
        end
        if (mag != 0) begin
            w.sign     = (v < 0);
            w.exponent = 8'(127 + lead);
            w.frac     = 23'(mag << (23 - lead));
        end
        return w;
    endfunction

    function automatic int random_int();
        int mag;
        mag = int'($urandom % 32'd1048576);
        return ($urandom % 2) ? -mag : mag;
    endfunction

    ////////////////////
    // one operation

    task automatic run_op(
        input fp_add_pkg::fp_word_t a,
        input fp_add_pkg::fp_word_t b,
        input logic                 sub,
        input fp_add_pkg::fp_word_t expected,
        input bit                   noise,
        input string                name
    );
        int                   waited;
        int                   pulses;
        fp_add_pkg::fp_word_t got;
        waited = 0;
        pulses = 0;
        got    = '0;
        @(posedge sys_clk);
        data1_in <= a;
        data2_in <= b;
        op       <= sub;
        trig     <= 1'b1;
        @(posedge sys_clk);
        trig <= 1'b0;
        while (pulses == 0 && waited < VLD_WAIT) begin
            @(posedge sys_clk);
            waited++;
            if (noise && waited <= 6) begin
                // triggers inside the busy window
                trig     <= 1'($urandom);
                data1_in <= fp_add_pkg::fp_word_t'($urandom);
                data2_in <= fp_add_pkg::fp_word_t'($urandom);
            end else begin
                trig <= 1'b0;
            end
            if (vld) begin
                pulses++;
                got = data_out;
            end
        end
        test_checks++;
        if (pulses == 0) begin
            $display("no vld within %0d cycles of the trigger in %s", VLD_WAIT, name);
            test_errors++;
        end else begin
            assert (got === expected) else begin
                $display("FAIL %s: data_out = %h, expected %h", name, got, expected);
                test_errors++;
            end
        end
        if (noise) begin
            repeat (8) begin
                @(posedge sys_clk);
                if (vld) begin
                    $display("extra vld pulse after a busy trigger in %s", name);
                    test_errors++;
                end
            end
        end
    endtask

    task automatic close_test(input string name);
        $display("test %s: checks %0d errors %0d", name, test_checks, test_errors);
        tests_run++;
        total_checks += test_checks;
        total_errors += test_errors;
        test_checks = 0;
        test_errors = 0;
    endtask

    ////////////////////
    // stimulus

    initial begin
        int                   va;
        int                   vb;
        logic                 sub;
        fp_add_pkg::fp_word_t x;
        data1_in <= '0;
        data2_in <= '0;
        op       <= 1'b0;
        trig     <= 1'b0;
        test_checks  = 0;
        test_errors  = 0;
        total_checks = 0;
        total_errors = 0;
        tests_run    = 0;
        void'($urandom(32'h36734087));
        wait (sys_rst_n === 1'b1);

        for (int i = 0; i < N_TIMING; i++) begin
            va  = random_int();
            vb  = random_int();
            sub = 1'($urandom);
            run_op(int_to_float(va), int_to_float(vb), sub,
                   int_to_float(sub ? va - vb : va + vb), 1'b1, "timing");
        end
        close_test("timing");

        for (int i = 0; i < N_EXACT; i++) begin
            va  = random_int();
            vb  = random_int();
            sub = 1'($urandom);
            run_op(int_to_float(va), int_to_float(vb), sub,
                   int_to_float(sub ? va - vb : va + vb), 1'b0, "exact");
        end
        close_test("exact");

        // tie goes to even, above half rounds up
        run_op(32'h3F800000, 32'h33800000, 1'b0, 32'h3F800000, 1'b0, "round_tie");
        run_op(32'h3F800000, 32'h33C00000, 1'b0, 32'h3F800001, 1'b0, "round_up");
        close_test("rounding");

        x = int_to_float(random_int());
        run_op(x, x, 1'b1, 32'h00000000, 1'b0, "cancel_int");
        run_op(32'h40490FDB, 32'h40490FDB, 1'b1, 32'h00000000, 1'b0, "cancel_pi");
        x = int_to_float(random_int());
        run_op(32'h00000123, x, 1'b0, x, 1'b0, "denormal");
        close_test("zero");

        run_op(32'h7FC00000, 32'h40A00000, 1'b0, 32'hFFFFFFFF, 1'b0, "nan_a");
        run_op(32'h40A00000, 32'hFF800001, 1'b1, 32'hFFFFFFFF, 1'b0, "nan_b");
        run_op(32'h7F800000, 32'h7F800000, 1'b1, 32'hFFFFFFFF, 1'b0, "inf_minus_inf");
        run_op(32'h7F800000, 32'h40A00000, 1'b0, 32'h7F800000, 1'b0, "inf_plus_5");
        run_op(32'h40A00000, 32'h7F800000, 1'b1, 32'hFF800000, 1'b0, "5_minus_inf");
        close_test("specials");

        run_op(32'h7F7FFFFF, 32'h7F7FFFFF, 1'b0, 32'h7F800000, 1'b0, "max_plus_max");
        close_test("overflow");

        $display("tests %0d checks %0d errors %0d assertion failures %0d",
                 tests_run, total_checks, total_errors, UUT.u_asserts.fail_count);
        if (total_errors == 0 && UUT.u_asserts.fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // watchdog sized from the operation count
    initial begin
        #(CLK_NS * (RST_CYCLES + N_OPS * OP_CYCLES));
        $display("watchdog expired before all tests finished");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: tb.f
hw/fp_add_pkg.sv
hw/fp_add_seq.sv
hw/fp_unpack.sv
hw/fp_align.sv
hw/fp_signed_sum.sv
hw/fp_normalize.sv
hw/fp_pack.sv
hw/fp_add_top.sv
verification/fp_add_asserts.sv
verification/tb_clk_gen.sv
verification/tb_fp_add.sv

// File: run_sim.sh
#!/bin/sh
# build and run the fp_add testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_fp_add -o sim_fp_add
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_fp_add +verilator+error+limit+1000 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q -x "=== PASS ===" "$LOG"; then
    exit 0
fi
exit 1
